/* nnLayer.f */
+incdir+.
nnPkg.sv
nnAxiDecode.sv
nnNeuronArray.sv
nnActivation.sv
nnLayer.sv
nnLayerTb.sv

/* run.sh */
#!/bin/sh
# Builds the nnLayer testbench with Verilator and runs it.
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --top-module nnLayerTb -Mdir obj_dir \
	-o nnLayerSim -f nnLayer.f
buildStatus=$?
if [ $buildStatus -ne 0 ]; then
	echo "Verilator build failed with status $buildStatus"
	exit 1
fi

./obj_dir/nnLayerSim > "$LOG" 2>&1
simStatus=$?
cat "$LOG"
if [ $simStatus -ne 0 ]; then
	echo "Simulation exited with status $simStatus"
	exit 1
fi

if grep -q "Test FAILED" "$LOG"; then
	echo "Failures found in $LOG"
	exit 1
fi

exit 0

/* nnLayerTb.sv */
`timescale 1ns/1ps
`include "nnLayer_consts.svh"

module nnLayerTb;

	// Four times the length of about 40 computations of 110 cycles each plus loading.
	localparam int TIMEOUT_CYCLES = 20000;

	logic clk;
	logic reset;
	nnPkg::axiLiteReq_t axiReq;
	nnPkg::axiLiteRsp_t axiRsp;

	integer seed;
	int cycles = 0;
	int checkCount = 0;
	int errorCount = 0;
	int testErrors = 0;
	logic signed [15:0] inModel [`NN_INPUTS];
	logic signed [15:0] wModel [`NN_NEURONS][`NN_INPUTS+1];

	nnLayer dut0 (.clk(clk), .reset(reset), .axiReq(axiReq), .axiRsp(axiRsp));

	initial
	begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	always @(posedge clk)
	begin
		cycles++;
		if (cycles >= TIMEOUT_CYCLES)
		begin
			$display("Timeout after %0d cycles, the tests did not finish.", cycles);
			$display("Test FAILED");
			$finish;
		end
	end

	function automatic logic [15:0] mergeModel(input logic [15:0] old,
			input logic [31:0] data, input logic [3:0] strb);
		logic [15:0] mask;
		mask = {{8{strb[1]}}, {8{strb[0]}}};
		return (old & ~mask) | (data[15:0] & mask);
	endfunction

	function automatic logic [31:0] wordOf(input logic [15:0] v);
		return {{16{v[15]}}, v};
	endfunction

	// Keeps the low 16 bits of each product, wraps the sum with the bias, then applies ReLU.
	function automatic logic [15:0] neuronRef(input int n);
		logic [15:0] acc;
		logic signed [31:0] prod;
		acc = wModel[n][`NN_INPUTS];
		for (int i = 0; i < `NN_INPUTS; i++)
		begin
			prod = 32'(inModel[i]) * 32'(wModel[n][i]);
			acc = acc + prod[15:0];
		end
		if (acc[15])
			acc = '0;
		return acc;
	endfunction

	task automatic checkValue(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		checkCount++;
		if (got !== exp)
		begin
			$display("ERROR at %0t: %s is %h, expected %h", $time, name, got, exp);
			errorCount++;
		end
	endtask

	task automatic axiWrite(input logic [11:0] addr, input logic [31:0] data,
			input logic [3:0] strb, output logic [1:0] resp);
		int delay;
		axiReq.awaddr = addr;
		axiReq.wdata = data;
		axiReq.wstrb = strb;
		axiReq.awvalid = 1'b1;
		axiReq.wvalid = 1'b1;
		// Address and data transfer on the rising edge after awready shows up.
		do
			@(negedge clk);
		while (!axiRsp.awready);
		checkValue("wready", 32'(axiRsp.wready), 32'h1);
		@(negedge clk);
		axiReq.awvalid = 1'b0;
		axiReq.wvalid = 1'b0;
		delay = $unsigned($random(seed)) % 4;
		repeat (delay) @(negedge clk);
		axiReq.bready = 1'b1;
		while (!axiRsp.bvalid)
			@(negedge clk);
		resp = axiRsp.bresp;
		@(negedge clk);
		axiReq.bready = 1'b0;
	endtask

	task automatic axiRead(input logic [11:0] addr, output logic [31:0] data,
			output logic [1:0] resp);
		int delay;
		axiReq.araddr = addr;
		axiReq.arvalid = 1'b1;
		do
			@(negedge clk);
		while (!axiRsp.arready);
		@(negedge clk);
		axiReq.arvalid = 1'b0;
		delay = $unsigned($random(seed)) % 4;
		repeat (delay) @(negedge clk);
		axiReq.rready = 1'b1;
		while (!axiRsp.rvalid)
			@(negedge clk);
		data = axiRsp.rdata;
		resp = axiRsp.rresp;
		@(negedge clk);
		axiReq.rready = 1'b0;
	endtask

	task automatic writeInput(input int idx, input logic [31:0] data, input logic [3:0] strb);
		logic [1:0] resp;
		axiWrite(12'(`NN_ADDR_INPUT + 4 * idx), data, strb, resp);
		checkValue("bresp", 32'(resp), 32'(`NN_RESP_OKAY));
		inModel[idx] = mergeModel(inModel[idx], data, strb);
	endtask

	task automatic writeWeight(input int n, input int idx, input logic [31:0] data,
			input logic [3:0] strb);
		logic [1:0] resp;
		axiWrite(12'(`NN_ADDR_WEIGHT + `NN_WEIGHT_STRIDE * n + 4 * idx), data, strb, resp);
		checkValue("bresp", 32'(resp), 32'(`NN_RESP_OKAY));
		wModel[n][idx] = mergeModel(wModel[n][idx], data, strb);
	endtask

	task automatic startLayer();
		logic [1:0] resp;
		axiWrite(`NN_ADDR_CTRL, 32'h1, 4'h1, resp);
		checkValue("bresp", 32'(resp), 32'(`NN_RESP_OKAY));
	endtask

	task automatic waitDone();
		logic [31:0] status;
		logic [1:0] resp;
		status = '0;
		while (!status[1])
			axiRead(`NN_ADDR_STATUS, status, resp);
		// Busy falls one cycle after done rises, so a second read shows done alone.
		axiRead(`NN_ADDR_STATUS, status, resp);
		checkValue("status", status, 32'h2);
	endtask

	task automatic checkResults();
		logic [31:0] data;
		logic [1:0] resp;
		for (int n = 0; n < `NN_NEURONS; n++)
		begin
			axiRead(12'(`NN_ADDR_RESULT + 4 * n), data, resp);
			checkValue($sformatf("result[%0d]", n), data, wordOf(neuronRef(n)));
			checkValue("rresp", 32'(resp), 32'(`NN_RESP_OKAY));
		end
	endtask

	task automatic verifyStored();
		logic [31:0] data;
		logic [1:0] resp;
		for (int i = 0; i < `NN_INPUTS; i++)
		begin
			axiRead(12'(`NN_ADDR_INPUT + 4 * i), data, resp);
			checkValue($sformatf("input[%0d]", i), data, wordOf(inModel[i]));
		end
		for (int n = 0; n < `NN_NEURONS; n++)
			for (int i = 0; i <= `NN_INPUTS; i++)
			begin
				axiRead(12'(`NN_ADDR_WEIGHT + `NN_WEIGHT_STRIDE * n + 4 * i), data, resp);
				checkValue($sformatf("weight[%0d][%0d]", n, i), data, wordOf(wModel[n][i]));
			end
	endtask

	task automatic reportTest(input string name);
		$display("%s finished with %0d errors", name, errorCount - testErrors);
		testErrors = errorCount;
	endtask

	initial
	begin
		int v;
		logic [31:0] rnd;
		logic [31:0] data;
		logic [1:0] resp;
		logic [11:0] badAddr [6];
		seed = 32'h1424_62f6;
		reset = 1'b1;
		axiReq = '0;
		for (int i = 0; i < `NN_INPUTS; i++)
			inModel[i] = '0;
		for (int n = 0; n < `NN_NEURONS; n++)
			for (int i = 0; i <= `NN_INPUTS; i++)
				wModel[n][i] = '0;
		repeat (5) @(negedge clk);
		reset = 1'b0;

		axiRead(`NN_ADDR_STATUS, data, resp);
		checkValue("status", data, 32'h0);
		checkResults();
		verifyStored();
		reportTest("reset values");

		for (int n = 0; n < `NN_NEURONS; n++)
			for (int i = 0; i <= `NN_INPUTS; i++)
			begin
				rnd = $random(seed);
				writeWeight(n, i, rnd, 4'hf);
			end
		// A second write with random strobes updates only the selected bytes.
		for (int i = 0; i < `NN_INPUTS; i++)
		begin
			rnd = $random(seed);
			writeInput(i, rnd, 4'hf);
			rnd = $random(seed);
			writeInput(i, rnd, rnd[31:28]);
		end
		verifyStored();
		reportTest("register storage");

		for (int t = 0; t < 40; t++)
		begin
			for (int i = 0; i < `NN_INPUTS; i++)
			begin
				rnd = $random(seed);
				writeInput(i, rnd, 4'hf);
			end
			startLayer();
			waitDone();
			checkResults();
		end
		reportTest("random vectors");

		// Positive inputs against negative weights and biases give negative sums.
		for (int i = 0; i < `NN_INPUTS; i++)
		begin
			v = 1 + ($unsigned($random(seed)) % 15);
			writeInput(i, 32'(v), 4'hf);
		end
		for (int n = 0; n < `NN_NEURONS; n++)
			for (int i = 0; i <= `NN_INPUTS; i++)
			begin
				v = 1 + ($unsigned($random(seed)) % 15);
				writeWeight(n, i, 32'(-v), 4'hf);
			end
		startLayer();
		waitDone();
		for (int n = 0; n < `NN_NEURONS; n++)
		begin
			axiRead(12'(`NN_ADDR_RESULT + 4 * n), data, resp);
			checkValue($sformatf("result[%0d]", n), data, 32'h0);
		end
		for (int i = 0; i < `NN_INPUTS; i++)
		begin
			rnd = $random(seed);
			writeInput(i, {16'h0, 4'h7, rnd[11:0]}, 4'hf);
		end
		for (int n = 0; n < `NN_NEURONS; n++)
			for (int i = 0; i <= `NN_INPUTS; i++)
			begin
				rnd = $random(seed);
				writeWeight(n, i, {16'h0, 4'h7, rnd[11:0]}, 4'hf);
			end
		startLayer();
		waitDone();
		checkResults();
		reportTest("negative and overflow");

		badAddr = '{12'h03C, 12'h0C0, 12'h208, 12'h310, 12'hFFC, 12'h002};
		for (int k = 0; k < 6; k++)
		begin
			axiWrite(badAddr[k], 32'hFFFF_FFFF, 4'hf, resp);
			checkValue("bresp", 32'(resp), 32'(`NN_RESP_SLVERR));
			axiRead(badAddr[k], data, resp);
			checkValue("rresp", 32'(resp), 32'(`NN_RESP_SLVERR));
		end
		axiWrite(`NN_ADDR_STATUS, 32'h3, 4'hf, resp);
		checkValue("bresp", 32'(resp), 32'(`NN_RESP_SLVERR));
		for (int n = 0; n < `NN_NEURONS; n++)
		begin
			axiWrite(12'(`NN_ADDR_RESULT + 4 * n), 32'h1234, 4'hf, resp);
			checkValue("bresp", 32'(resp), 32'(`NN_RESP_SLVERR));
		end
		verifyStored();
		checkResults();
		reportTest("error responses");

		for (int i = 0; i < `NN_INPUTS; i++)
		begin
			rnd = $random(seed);
			writeInput(i, rnd, 4'hf);
		end
		startLayer();
		rnd = $random(seed);
		writeInput(0, rnd, 4'hf);
		rnd = $random(seed);
		writeInput(`NN_INPUTS - 1, rnd, 4'hf);
		startLayer();
		waitDone();
		checkResults();
		reportTest("back to back starts");

		$display("%0d checks, %0d errors", checkCount, errorCount);
		if (errorCount == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule

/* nnLayer.sv */
`timescale 1ns/1ps

module nnLayer (
	input logic clk,
	input logic reset,
	input nnPkg::axiLiteReq_t axiReq,
	output nnPkg::axiLiteRsp_t axiRsp
);

	logic start;
	nnPkg::sampleVec_t inputs;
	nnPkg::weightBank_t weights;
	nnPkg::sumVec_t sums;
	logic sumValid;
	nnPkg::sumVec_t results;
	logic done;

	nnAxiDecode decode0 (
		.clk(clk),
		.reset(reset),
		.axiReq(axiReq),
		.axiRsp(axiRsp),
		.start(start),
		.inputs(inputs),
		.weights(weights),
		.results(results),
		.done(done)
	);

	nnNeuronArray array0 (
		.clk(clk),
		.reset(reset),
		.start(start),
		.inputs(inputs),
		.weights(weights),
		.sums(sums),
		.sumValid(sumValid)
	);

	nnActivation act0 (
		.clk(clk),
		.reset(reset),
		.sums(sums),
		.sumValid(sumValid),
		.start(start),
		.results(results),
		.done(done)
	);

endmodule

/* nnActivation.sv */
`timescale 1ns/1ps
`include "nnLayer_consts.svh"

module nnActivation (
	input logic clk,
	input logic reset,
	input nnPkg::sumVec_t sums,
	input logic sumValid,
	input logic start,
	output nnPkg::sumVec_t results,
	output logic done
);

	function automatic nnPkg::sum_t relu(input nnPkg::sum_t val);
		if (val[`NN_DATA_W-1])
			return '0;
		return val;
	endfunction

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			results <= '0;
			done <= 1'b0;
		end
		else
		begin
			if (sumValid)
			begin
				for (int n = 0; n < `NN_NEURONS; n++)
					results[n] <= relu(sums[n]);
			end
			// A finishing result wins over a new start in the same cycle.
			done <= sumValid | (done & ~start);
		end
	end

	genvar n;
	generate
		for (n = 0; n < `NN_NEURONS; n++)
		begin : gCheck
			assert property (@(posedge clk) disable iff (reset)
				!results[n][`NN_DATA_W-1]);
		end
	endgenerate

endmodule

/* nnNeuronArray.sv */
`timescale 1ns/1ps
`include "nnLayer_consts.svh"

module nnNeuronArray (
	input logic clk,
	input logic reset,
	input logic start,
	input nnPkg::sampleVec_t inputs,
	input nnPkg::weightBank_t weights,
	output nnPkg::sumVec_t sums,
	output logic sumValid
);

	nnPkg::sampleVec_t inputsQ;
	logic opValid;

	// The input vector is shared by every neuron.
	always_ff @(posedge clk)
	begin
		if (start)
			inputsQ <= inputs;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			opValid <= 1'b0;
			sumValid <= 1'b0;
		end
		else
		begin
			opValid <= start;
			sumValid <= opValid;
		end
	end

	genvar n;
	generate
		for (n = 0; n < `NN_NEURONS; n++)
		begin : gNeuron
			nnPkg::sample_t [`NN_INPUTS:0] weightsQ;
			nnPkg::sum_t acc;

			always_ff @(posedge clk)
			begin
				if (start)
					weightsQ <= weights[n];
			end

			// Products keep only their low 16 bits and the sum wraps around.
			always_comb
			begin
				acc = weightsQ[`NN_INPUTS];
				for (int i = 0; i < `NN_INPUTS; i++)
					acc = acc + nnPkg::sum_t'(inputsQ[i] * weightsQ[i]);
			end

			always_ff @(posedge clk)
			begin
				if (opValid)
					sums[n] <= acc;
			end
		end
	endgenerate

	assert property (@(posedge clk) disable iff (reset)
		sumValid |-> $past(start, 2));

endmodule

/* nnAxiDecode.sv */
`timescale 1ns/1ps
`include "nnLayer_consts.svh"

module nnAxiDecode (
	input logic clk,
	input logic reset,
	input nnPkg::axiLiteReq_t axiReq,
	output nnPkg::axiLiteRsp_t axiRsp,
	output logic start,
	output nnPkg::sampleVec_t inputs,
	output nnPkg::weightBank_t weights,
	input nnPkg::sumVec_t results,
	input logic done
);

	nnPkg::wrState_t wrState;
	nnPkg::rdState_t rdState;
	nnPkg::addrDec_t wrDec;
	nnPkg::addrDec_t rdDec;
	nnPkg::axiResp_t bresp;
	nnPkg::axiResp_t rresp;
	nnPkg::axiData_t rdata;
	nnPkg::axiData_t rdWord;
	logic rdOk;
	logic wrOk;
	logic busy;

	function automatic nnPkg::addrDec_t decodeAddr(input nnPkg::axiAddr_t addr);
		nnPkg::addrDec_t dec;
		nnPkg::axiAddr_t inOff;
		nnPkg::axiAddr_t wOff;
		nnPkg::axiAddr_t resOff;
		dec = '0;
		inOff = addr - `NN_ADDR_INPUT;
		wOff = addr - `NN_ADDR_WEIGHT;
		resOff = addr - `NN_ADDR_RESULT;
		// Only word-aligned addresses are mapped.
		if (addr[1:0] == 2'b00)
		begin
			if (inOff < nnPkg::axiAddr_t'(4 * `NN_INPUTS))
			begin
				dec.isInput = 1'b1;
				dec.index = inOff[5:2];
			end
			else if (wOff < nnPkg::axiAddr_t'(`NN_WEIGHT_STRIDE * `NN_NEURONS))
			begin
				dec.isWeight = 1'b1;
				dec.neuron = wOff[7:6];
				dec.index = wOff[5:2];
			end
			else if (addr == `NN_ADDR_CTRL)
				dec.isCtrl = 1'b1;
			else if (addr == `NN_ADDR_STATUS)
				dec.isStatus = 1'b1;
			else if (resOff < nnPkg::axiAddr_t'(4 * `NN_NEURONS))
			begin
				dec.isResult = 1'b1;
				dec.neuron = resOff[3:2];
			end
		end
		return dec;
	endfunction

	function automatic nnPkg::sample_t mergeBytes(input nnPkg::sample_t old,
			input nnPkg::axiData_t data, input nnPkg::axiStrb_t strb);
		nnPkg::sample_t val;
		val = old;
		if (strb[0])
			val[7:0] = data[7:0];
		if (strb[1])
			val[15:8] = data[15:8];
		return val;
	endfunction

	function automatic nnPkg::axiData_t signExtend(input logic [`NN_DATA_W-1:0] val);
		return {{($bits(nnPkg::axiData_t) - `NN_DATA_W){val[`NN_DATA_W-1]}}, val};
	endfunction

	assign wrDec = decodeAddr(axiReq.awaddr);
	assign rdDec = decodeAddr(axiReq.araddr);
	assign wrOk = wrDec.isInput | wrDec.isWeight | wrDec.isCtrl;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			wrState <= nnPkg::WR_IDLE;
			start <= 1'b0;
			busy <= 1'b0;
			inputs <= '0;
			weights <= '0;
		end
		else
		begin
			start <= 1'b0;
			busy <= start | (busy & ~done);
			case (wrState)
				nnPkg::WR_IDLE:
					if (axiReq.awvalid && axiReq.wvalid)
						wrState <= nnPkg::WR_ACCEPT;
				nnPkg::WR_ACCEPT:
				begin
					// Address and data handshake together in this cycle.
					wrState <= nnPkg::WR_RESP;
					if (wrDec.isInput)
						inputs[wrDec.index] <= mergeBytes(inputs[wrDec.index],
							axiReq.wdata, axiReq.wstrb);
					if (wrDec.isWeight)
						weights[wrDec.neuron][wrDec.index] <= mergeBytes(
							weights[wrDec.neuron][wrDec.index], axiReq.wdata, axiReq.wstrb);
					if (wrDec.isCtrl && axiReq.wstrb[0] && axiReq.wdata[0])
					begin
						start <= 1'b1;
						busy <= 1'b1;
					end
				end
				nnPkg::WR_RESP:
					if (axiReq.bready)
						wrState <= nnPkg::WR_IDLE;
				default:
					wrState <= nnPkg::WR_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			rdState <= nnPkg::RD_IDLE;
		else
		begin
			case (rdState)
				nnPkg::RD_IDLE:
					if (axiReq.arvalid)
						rdState <= nnPkg::RD_ACCEPT;
				nnPkg::RD_ACCEPT:
					rdState <= nnPkg::RD_DATA;
				nnPkg::RD_DATA:
					if (axiReq.rready)
						rdState <= nnPkg::RD_IDLE;
				default:
					rdState <= nnPkg::RD_IDLE;
			endcase
		end
	end

	// Control reads back as zero since start is a pulse.
	always_comb
	begin
		rdWord = '0;
		rdOk = 1'b1;
		if (rdDec.isInput)
			rdWord = signExtend(inputs[rdDec.index]);
		else if (rdDec.isWeight)
			rdWord = signExtend(weights[rdDec.neuron][rdDec.index]);
		else if (rdDec.isStatus)
			rdWord = nnPkg::axiData_t'({done, busy});
		else if (rdDec.isResult)
			rdWord = signExtend(results[rdDec.neuron]);
		else if (!rdDec.isCtrl)
			rdOk = 1'b0;
	end

	always_ff @(posedge clk)
	begin
		if (wrState == nnPkg::WR_ACCEPT)
			bresp <= wrOk ? `NN_RESP_OKAY : `NN_RESP_SLVERR;
		if (rdState == nnPkg::RD_ACCEPT)
		begin
			rdata <= rdWord;
			rresp <= rdOk ? `NN_RESP_OKAY : `NN_RESP_SLVERR;
		end
	end

	always_comb
	begin
		axiRsp.awready = (wrState == nnPkg::WR_ACCEPT);
		axiRsp.wready = (wrState == nnPkg::WR_ACCEPT);
		axiRsp.bvalid = (wrState == nnPkg::WR_RESP);
		axiRsp.bresp = bresp;
		axiRsp.arready = (rdState == nnPkg::RD_ACCEPT);
		axiRsp.rvalid = (rdState == nnPkg::RD_DATA);
		axiRsp.rdata = rdata;
		axiRsp.rresp = rresp;
	end

	assert property (@(posedge clk) disable iff (reset)
		axiRsp.bvalid && !axiReq.bready |=> axiRsp.bvalid);

	assert property (@(posedge clk) disable iff (reset)
		axiRsp.rvalid && !axiReq.rready |=> axiRsp.rvalid);

	assert property (@(posedge clk) disable iff (reset) start |=> !start);

endmodule

/* nnPkg.sv */
`include "nnLayer_consts.svh"

package nnPkg;

	typedef logic signed [`NN_DATA_W-1:0] sample_t;
	typedef logic signed [`NN_DATA_W-1:0] sum_t;

	typedef logic [11:0] axiAddr_t;
	typedef logic [31:0] axiData_t;
	typedef logic [3:0] axiStrb_t;
	typedef logic [1:0] axiResp_t;

	typedef sample_t [`NN_INPUTS-1:0] sampleVec_t;
	// Index NN_INPUTS of each neuron holds its bias.
	typedef sample_t [`NN_NEURONS-1:0][`NN_INPUTS:0] weightBank_t;
	typedef sum_t [`NN_NEURONS-1:0] sumVec_t;

	typedef struct packed {
		axiAddr_t awaddr;
		logic awvalid;
		axiData_t wdata;
		axiStrb_t wstrb;
		logic wvalid;
		logic bready;
		axiAddr_t araddr;
		logic arvalid;
		logic rready;
	} axiLiteReq_t;

	typedef struct packed {
		logic awready;
		logic wready;
		logic arready;
		logic bvalid;
		axiResp_t bresp;
		logic rvalid;
		axiData_t rdata;
		axiResp_t rresp;
	} axiLiteRsp_t;

	typedef struct packed {
		logic isInput;
		logic isWeight;
		logic isCtrl;
		logic isStatus;
		logic isResult;
		logic [1:0] neuron;
		logic [3:0] index;
	} addrDec_t;

	typedef enum logic [1:0] {WR_IDLE, WR_ACCEPT, WR_RESP} wrState_t;
	typedef enum logic [1:0] {RD_IDLE, RD_ACCEPT, RD_DATA} rdState_t;

endpackage

/* nnLayer_consts.svh */
`ifndef NN_LAYER_CONSTS_SVH
`define NN_LAYER_CONSTS_SVH

// Layer geometry.
`define NN_NEURONS 4
`define NN_INPUTS 15
`define NN_DATA_W 16

// Each neuron owns a block of 64 bytes in the weight region and its bias sits last.
`define NN_WEIGHT_STRIDE 64

// Register map in byte addresses on the 12-bit AXI4-Lite bus.
`define NN_ADDR_INPUT 12'h000
`define NN_ADDR_WEIGHT 12'h100
`define NN_ADDR_CTRL 12'h200
`define NN_ADDR_STATUS 12'h204
`define NN_ADDR_RESULT 12'h300

// AXI response codes.
`define NN_RESP_OKAY 2'b00
`define NN_RESP_SLVERR 2'b10

`endif
